// ==== verilog/mips_cfg.svh ====
/*
 * core configuration macros
 * datapath and address widths, register count, reset pc
 */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ==============================
// datapath
// ==============================
`define MIPS_DATA_W    32              // register and alu width
`define MIPS_REG_CNT   32              // architectural registers incl. r0

// ==============================
// instruction fetch
// ==============================
`define MIPS_ADDR_W    32              // byte address, word aligned
`define MIPS_RESET_PC  32'h0000_0000   // first address after reset

`endif

// ==== verilog/mipsIsaPkg.sv ====
/*
 * instruction set definitions
 * instruction word layout, opcode and function codes, alu operations
 */
package mipsIsaPkg;

    typedef logic [4:0] regIdx_t;

    // r-type layout; immediate and jump index overlay the low fields
    typedef struct packed {
        logic [5:0] opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    // ==============================
    // opcodes
    // ==============================
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;

    // function field of r-type
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnSlt   = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl
    } aluOp_t;

endpackage

// ==== verilog/mipsPipePkg.sv ====
/*
 * pipeline payload types
 * decoded control, decode/execute payload, register write port
 */
`include "mips_cfg.svh"

package mipsPipePkg;

    import mipsIsaPkg::*;

    typedef struct packed {
        aluOp_t aluOp;
        logic   useImm;     // second operand from immediate
        logic   regWrite;
        logic   beq;
        logic   bne;
        logic   jump;
    } ctrl_t;

    // ==============================
    // decode -> execute
    // ==============================
    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        regIdx_t                 rs;
        regIdx_t                 rt;
        logic [`MIPS_DATA_W-1:0] rsVal;
        logic [`MIPS_DATA_W-1:0] rtVal;
        logic [`MIPS_DATA_W-1:0] imm;      // already extended
        regIdx_t                 dest;
        logic [4:0]              shamt;
        logic [`MIPS_ADDR_W-1:0] nextPc;   // address after the instruction
        logic [25:0]             jumpIdx;
    } idEx_t;

    typedef struct packed {
        logic                    valid;
        regIdx_t                 dest;
        logic [`MIPS_DATA_W-1:0] data;
    } wbPort_t;

endpackage

// ==== verilog/fetchUnit.sv ====
/*
 * fetch stage
 * program counter and fetch/decode register
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  logic [`MIPS_ADDR_W-1:0] redirectPc,
    input  mipsIsaPkg::instr_t      instr,
    output logic [`MIPS_ADDR_W-1:0] instrAddr,
    output mipsIsaPkg::instr_t      ifInstr,
    output logic                    ifValid,
    output logic [`MIPS_ADDR_W-1:0] ifNextPc
);

    logic [`MIPS_ADDR_W-1:0] pc;
    logic [`MIPS_ADDR_W-1:0] pcPlus4;

    assign pcPlus4   = pc + `MIPS_ADDR_W'(4);
    assign instrAddr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `MIPS_RESET_PC;
            ifValid <= 1'b0;
        end else begin
            pc      <= redirect ? {redirectPc[`MIPS_ADDR_W-1:2], 2'b00} : pcPlus4;
            ifValid <= !redirect;   // younger fetch becomes a bubble
        end
    end

    always_ff @(posedge clk) begin
        ifInstr  <= instr;
        ifNextPc <= pcPlus4;
    end

endmodule

// ==== verilog/decodeUnit.sv ====
/*
 * decode stage
 * control generation, immediate extension, decode/execute register
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module decodeUnit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mipsIsaPkg::instr_t      ifInstr,
    input  logic                    ifValid,
    input  logic [`MIPS_ADDR_W-1:0] ifNextPc,
    input  logic                    redirect,
    output mipsIsaPkg::regIdx_t     rsAddr,
    output mipsIsaPkg::regIdx_t     rtAddr,
    input  logic [`MIPS_DATA_W-1:0] rsData,
    input  logic [`MIPS_DATA_W-1:0] rtData,
    output mipsPipePkg::idEx_t      idEx
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    ctrl_t                   ctrl;
    logic [15:0]             imm16;
    logic                    zeroExt;
    logic [`MIPS_DATA_W-1:0] immExt;
    regIdx_t                 dest;

    assign rsAddr = ifInstr.rs;
    assign rtAddr = ifInstr.rt;

    // ==============================
    // control
    // ==============================
    always_comb begin
        ctrl       = '0;    // unknown encodings never write
        ctrl.aluOp = aluAdd;
        case (ifInstr.opcode)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                case (ifInstr.funct)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnXor:   ctrl.aluOp = aluXor;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    fnSll:   ctrl.aluOp = aluSll;
                    fnSrl:   ctrl.aluOp = aluSrl;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opAndi: begin
                ctrl.aluOp    = aluAnd;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opBeq:   ctrl.beq  = 1'b1;
            opBne:   ctrl.bne  = 1'b1;
            opJ:     ctrl.jump = 1'b1;
            default: ;
        endcase
    end

    // logical immediates are zero-extended
    assign imm16   = {ifInstr.rd, ifInstr.shamt, ifInstr.funct};
    assign zeroExt = (ifInstr.opcode == opAndi) || (ifInstr.opcode == opOri);
    assign immExt  = zeroExt ? {{(`MIPS_DATA_W-16){1'b0}}, imm16}
                             : {{(`MIPS_DATA_W-16){imm16[15]}}, imm16};
    assign dest    = (ifInstr.opcode == opRtype) ? ifInstr.rd : ifInstr.rt;

    // ==============================
    // decode/execute register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else begin
            idEx.valid   <= ifValid && !redirect;   // flushed by a taken branch
            idEx.ctrl    <= ctrl;
            idEx.rs      <= ifInstr.rs;
            idEx.rt      <= ifInstr.rt;
            idEx.rsVal   <= rsData;
            idEx.rtVal   <= rtData;
            idEx.imm     <= immExt;
            idEx.dest    <= dest;
            idEx.shamt   <= ifInstr.shamt;
            idEx.nextPc  <= ifNextPc;
            idEx.jumpIdx <= {ifInstr.rs, ifInstr.rt, ifInstr.rd, ifInstr.shamt, ifInstr.funct};
        end
    end

endmodule

// ==== verilog/regFile.sv ====
/*
 * register file
 * two combinational read ports with write bypass, one write port
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mipsIsaPkg::regIdx_t     rsAddr,
    input  mipsIsaPkg::regIdx_t     rtAddr,
    output logic [`MIPS_DATA_W-1:0] rsData,
    output logic [`MIPS_DATA_W-1:0] rtData,
    input  mipsPipePkg::wbPort_t    wb
);

    import mipsIsaPkg::*;

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_CNT];

    // r0 reads zero and a same-cycle write passes straight through
    function automatic logic [`MIPS_DATA_W-1:0] readPort(input regIdx_t addr);
        if (addr == '0)
            return '0;
        else if (wb.valid && wb.dest == addr)
            return wb.data;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

// ==== verilog/executeUnit.sv ====
/*
 * execute stage
 * operand forwarding, alu, branch resolution, execute/writeback register
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module executeUnit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mipsPipePkg::idEx_t      idEx,
    output mipsPipePkg::wbPort_t    wb,
    output logic                    redirect,
    output logic [`MIPS_ADDR_W-1:0] redirectPc
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    logic [`MIPS_DATA_W-1:0] opA;
    logic [`MIPS_DATA_W-1:0] opB;
    logic [`MIPS_DATA_W-1:0] aluB;
    logic [`MIPS_DATA_W-1:0] aluResult;
    logic                    operandsEq;
    logic                    taken;
    logic [`MIPS_ADDR_W-1:0] branchTarget;
    logic [`MIPS_ADDR_W-1:0] jumpTarget;

    // ==============================
    // operand forwarding
    // ==============================
    // newest value comes from the writeback register
    assign opA  = (wb.valid && wb.dest == idEx.rs) ? wb.data : idEx.rsVal;
    assign opB  = (wb.valid && wb.dest == idEx.rt) ? wb.data : idEx.rtVal;
    assign aluB = idEx.ctrl.useImm ? idEx.imm : opB;

    // ==============================
    // alu
    // ==============================
    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluXor:  aluResult = opA ^ aluB;
            aluSlt: begin
                aluResult = ($signed(opA) < $signed(aluB)) ? `MIPS_DATA_W'(1) : '0;
            end
            aluSll:  aluResult = opB << idEx.shamt;   // shifts act on rt
            aluSrl:  aluResult = opB >> idEx.shamt;
            default: aluResult = '0;
        endcase
    end

    // ==============================
    // branch and jump
    // ==============================
    assign operandsEq = (opA == opB);
    assign taken      = idEx.valid && ((idEx.ctrl.beq && operandsEq) ||
                                       (idEx.ctrl.bne && !operandsEq) ||
                                       idEx.ctrl.jump);

    // word offset relative to the next address
    assign branchTarget = idEx.nextPc + {idEx.imm[`MIPS_ADDR_W-3:0], 2'b00};
    assign jumpTarget   = {idEx.nextPc[`MIPS_ADDR_W-1 -: 4], idEx.jumpIdx, 2'b00};

    assign redirect   = taken;   // same-cycle flush of fetch and decode
    assign redirectPc = idEx.ctrl.jump ? jumpTarget : branchTarget;

    // ==============================
    // execute/writeback register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= idEx.valid && idEx.ctrl.regWrite && (idEx.dest != '0);
            wb.dest  <= idEx.dest;
            wb.data  <= aluResult;
        end
    end

endmodule

// ==== verilog/mipsCore.sv ====
/*
 * four-stage pipelined integer core
 * fetch, decode, execute and register file wiring
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mipsIsaPkg::instr_t      instr,
    output logic [`MIPS_ADDR_W-1:0] instrAddr,
    output mipsPipePkg::wbPort_t    wb
);

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    instr_t                  ifInstr;
    logic                    ifValid;
    logic [`MIPS_ADDR_W-1:0] ifNextPc;
    regIdx_t                 rsAddr;
    regIdx_t                 rtAddr;
    logic [`MIPS_DATA_W-1:0] rsData;
    logic [`MIPS_DATA_W-1:0] rtData;
    idEx_t                   idEx;
    logic                    redirect;       // taken branch or jump
    logic [`MIPS_ADDR_W-1:0] redirectPc;

    fetchUnit i_fetch (
        .clk(clk), .rst_n(rst_n),
        .redirect(redirect), .redirectPc(redirectPc),
        .instr(instr), .instrAddr(instrAddr),
        .ifInstr(ifInstr), .ifValid(ifValid), .ifNextPc(ifNextPc)
    );

    decodeUnit i_decode (
        .clk(clk), .rst_n(rst_n),
        .ifInstr(ifInstr), .ifValid(ifValid), .ifNextPc(ifNextPc),
        .redirect(redirect),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .idEx(idEx)
    );

    regFile i_regFile (
        .clk(clk), .rst_n(rst_n),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .wb(wb)
    );

    executeUnit i_execute (
        .clk(clk), .rst_n(rst_n),
        .idEx(idEx), .wb(wb),
        .redirect(redirect), .redirectPc(redirectPc)
    );

endmodule

// ==== tests/mipsCore_props.sv ====
/*
 * concurrent assertions on the core ports
 * bound into mipsCore
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`MIPS_ADDR_W-1:0] instrAddr,
    input mipsPipePkg::wbPort_t    wb
);

    int assertFails = 0;    // failed assertion count

    // ==============================
    // writeback port
    // ==============================
    aWbQuietInReset: assert property (@(posedge clk) !rst_n |-> !wb.valid)
        else begin
            assertFails++;
            $error("wb.valid high while reset is held");
        end

    aWbNoR0: assert property (@(posedge clk) disable iff (!rst_n) wb.valid |-> wb.dest != '0)
        else begin
            assertFails++;
            $error("register write to r0 on wb");
        end

    // ==============================
    // fetch address
    // ==============================
    aAddrAligned: assert property (@(posedge clk) disable iff (!rst_n) instrAddr[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("instrAddr not word aligned");
        end

    aAddrKnown: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(instrAddr))
        else begin
            assertFails++;
            $error("instrAddr unknown after reset");
        end

endmodule

bind mipsCore mipsCore_props i_props (
    .clk(clk), .rst_n(rst_n), .instrAddr(instrAddr), .wb(wb)
);

// ==== tests/mipsCore_tb.sv ====
/*
 * testbench for the pipelined core
 * lfsr program generator, sequential instruction-set model, write checks
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mipsCore_tb;

    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    localparam int          progLen  = 64;
    localparam int          cycleMax = 3 * progLen + 20;
    localparam int          doneAddr = (progLen + 6) * 4;  // last instruction retired by then
    localparam logic [31:0] lfsrSeed = 32'h10c6_1bcf;
    // opcode of each kind in order, eight r-type then addi andi ori beq bne j
    localparam logic [5:0]  opOf [14] = '{0, 0, 0, 0, 0, 0, 0, 0, 8, 12, 13, 4, 5, 2};
    // add sub and or xor slt sll srl
    localparam logic [5:0]  fnOf [8] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02};
    localparam string       testName [4] = '{"aluRegReg", "immShift", "dependent", "afterBranch"};

    logic                    clk;
    logic                    rst_n;
    instr_t                  instr;
    logic [`MIPS_ADDR_W-1:0] instrAddr;
    wbPort_t                 wb;

    logic [31:0] prog [progLen];
    int          kind [progLen];
    logic [31:0] lfsr;
    wbPort_t     expQ [$];
    logic [3:0]  tagQ [$];     // one bit per tagged test
    int          checks [4] = '{default: 0};
    int          errs [4]   = '{default: 0};
    int          writes     = 0;
    int          r0Writes   = 0;
    int          failures   = 0;
    int          cycles     = 0;
    int          expCount   = 0;

    // instruction memory with zero words past the program
    assign instr = (instrAddr < progLen * 4) ? prog[instrAddr[7:2]] : '0;

    mipsCore i_dut (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instrAddr(instrAddr), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    // ==============================
    // random program
    // ==============================
    task automatic genProgram();
        logic [31:0] k, rs, rt, rd, sh, imm;
        for (int a = 0; a < progLen; a++) begin
            takeBits(4, k);
            takeBits(3, rs);   // r0 to r7 only
            takeBits(3, rt);
            takeBits(3, rd);
            takeBits(5, sh);
            takeBits(16, imm);
            if (k >= 14)
                k = (k == 14) ? 8 : 10;   // extra addi and ori seed the registers
            kind[a] = k;
            if (k < 8)
                prog[a] = {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fnOf[k]};
            else if (k < 11)
                prog[a] = {opOf[k], rs[4:0], rt[4:0], imm[15:0]};
            else if (k < 13)
                prog[a] = {opOf[k], rs[4:0], rt[4:0], 14'h0, imm[1:0]};   // 0 to 3 words on
            else
                prog[a] = {opOf[k], 26'(a + 1 + imm[1:0])};   // 1 to 4 words ahead
        end
    endtask

    // sequential execution of one instruction at a time
    task automatic runModel();
        logic [31:0] r [32];
        logic [31:0] a, b, res;
        logic [15:0] imm;
        instr_t      w;
        regIdx_t     dest, last0, last1;
        int          pc, cur;
        bit          wr, dep, afterCtl;
        foreach (r[i]) r[i] = '0;
        pc       = 0;
        last0    = '0;
        last1    = '0;
        afterCtl = 1'b0;
        while (pc < progLen) begin
            cur  = pc;
            w    = prog[cur];
            imm  = prog[cur][15:0];
            a    = r[w.rs];
            b    = r[w.rt];
            res  = '0;
            pc   = cur + 1;
            wr   = kind[cur] < 11;
            dest = (kind[cur] < 8) ? w.rd : w.rt;
            // rs read by all but shifts and rt only by r-type
            dep = (kind[cur] != 6 && kind[cur] != 7 && w.rs != 0 &&
                   (w.rs == last0 || w.rs == last1)) ||
                  (kind[cur] < 8 && w.rt != 0 && (w.rt == last0 || w.rt == last1));
            case (kind[cur])
                0:  res = a + b;
                1:  res = a - b;
                2:  res = a & b;
                3:  res = a | b;
                4:  res = a ^ b;
                5:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6:  res = b << w.shamt;
                7:  res = b >> w.shamt;
                8:  res = a + {{16{imm[15]}}, imm};
                9:  res = a & {16'h0, imm};
                10: res = a | {16'h0, imm};
                11: if (a == b) pc = cur + 1 + imm;
                12: if (a != b) pc = cur + 1 + imm;
                default: pc = int'(prog[cur][25:0]);   // word index of the target
            endcase
            if (wr && dest != 0) begin
                r[dest] = res;
                expQ.push_back('{valid: 1'b1, dest: dest, data: res});
                tagQ.push_back({afterCtl, dep, kind[cur] >= 6, kind[cur] < 6});
            end
            afterCtl = !wr;
            last1    = last0;
            last0    = (wr && dest != 0) ? dest : '0;
        end
    endtask

    // ==============================
    // compare tasks
    // ==============================
    task automatic checkWb(input string name, input wbPort_t expected, input wbPort_t actual,
                           output bit ok);
        ok = (expected === actual);
        if (!ok)
            $display("mismatch %s: expected r%0d=%h, actual r%0d=%h", name,
                     expected.dest, expected.data, actual.dest, actual.data);
    endtask

    task automatic checkCount(input string name, input int expected, input int actual,
                              output bit ok);
        ok = (expected == actual);
        if (!ok)
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    always @(posedge clk) begin
        if (rst_n)
            cycles <= cycles + 1;
    end

    // wb holds a full cycle so it is sampled mid-cycle
    always @(negedge clk) begin
        wbPort_t    expWr;
        logic [3:0] tag;
        bit         ok;
        if (rst_n && wb.valid) begin
            writes++;
            if (wb.dest == '0) begin
                r0Writes++;
                failures++;
                $display("write to r0 seen on wb with data %h", wb.data);
            end
            if (expQ.size() == 0) begin
                failures++;
                $display("write to r%0d with data %h has no counterpart in the model",
                         wb.dest, wb.data);
            end else begin
                expWr = expQ.pop_front();
                tag   = tagQ.pop_front();
                checkWb($sformatf("%s[%0d]", testName[tag[0] ? 0 : 1], writes),
                        expWr, wb, ok);
                for (int t = 0; t < 4; t++) begin
                    if (tag[t]) begin
                        checks[t]++;
                        if (!ok) errs[t]++;
                    end
                end
                if (!ok) failures++;
            end
        end
    end

    initial begin
        wait (cycles >= cycleMax);
        $display("timeout after %0d cycles, %0d of %0d writes seen", cycles, writes, expCount);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // main sequence
    // ==============================
    initial begin
        bit ok;
        int failedTests;
        int propFails;
        rst_n       = 1'b0;
        lfsr        = lfsrSeed;
        failedTests = 0;
        genProgram();
        runModel();
        expCount = expQ.size();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        while (instrAddr < doneAddr)
            @(posedge clk);
        for (int t = 0; t < 4; t++) begin
            $display("test %-12s %0d writes checked, %0d mismatches",
                     testName[t], checks[t], errs[t]);
            if (errs[t] != 0) failedTests++;
        end
        $display("test %-12s %0d writes to r0", "noR0Write", r0Writes);
        if (r0Writes != 0) failedTests++;
        checkCount("writeCount", expCount, writes, ok);
        $display("test %-12s expected %0d, seen %0d", "writeCount", expCount, writes);
        if (!ok) begin
            failedTests++;
            failures++;
        end
        propFails = i_dut.i_props.assertFails;
        $display("test %-12s %0d assertion failures", "portProps", propFails);
        if (propFails != 0) begin
            failedTests++;
            failures += propFails;
        end
        $display("7 tests, %0d failed, %0d errors in %0d cycles", failedTests, failures, cycles);
        if (failures == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/mipsIsaPkg.sv
verilog/mipsPipePkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/mipsCore.sv
tests/mipsCore_props.sv
tests/mipsCore_tb.sv
